//--- exu_config.svh
// execute stage parameters
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// data path word
`define EXU_DATA_WIDTH 32

// register file index
`define EXU_REG_ADDR_WIDTH 5

// csr address space
`define EXU_CSR_ADDR_WIDTH 12

// each performance counter, wraps on overflow
`define EXU_PERF_WIDTH 32

`endif

//--- exu_pkg.sv
// execute stage types
`default_nettype none

package exu_pkg;

	// alu operation, unused codes give a zero result
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_SLL   = 4'd2,
		ALU_SLT   = 4'd3,
		ALU_SLTU  = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SRA   = 4'd7,
		ALU_OR    = 4'd8,
		ALU_AND   = 4'd9,
		ALU_PASS2 = 4'd10
	} alu_op_e;

	// first operand source
	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2,
		SRC1_CSR  = 2'd3
	} src1_sel_e;

	// second operand source
	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_REG2 = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3
	} src2_sel_e;

	typedef enum logic [2:0] {
		CSR_NONE  = 3'd0,
		CSR_CSRRW = 3'd1,
		CSR_CSRRS = 3'd2
	} csr_op_e;

	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_LB   = 3'd1,
		LOAD_LH   = 3'd2,
		LOAD_LW   = 3'd3,
		LOAD_LBU  = 3'd4,
		LOAD_LHU  = 3'd5
	} load_type_e;

	// non-zero means a store
	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		STORE_SB   = 2'd1,
		STORE_SH   = 2'd2,
		STORE_SW   = 2'd3
	} store_type_e;

endpackage

`default_nettype wire

//--- alu.sv
// rv32 integer alu
`default_nettype none
`include "exu_config.svh"

module alu (
	input  wire logic [`EXU_DATA_WIDTH-1:0] src1_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0] src2_i,
	input  wire exu_pkg::alu_op_e           op_i,
	output logic [`EXU_DATA_WIDTH-1:0]      result_o
);

	import exu_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// only the low five bits count for rv32 shifts
	assign shamt = src2_i[4:0];

	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		case (op_i)
			ALU_ADD: begin
				result_o = src1_i + src2_i;
			end
			ALU_SUB: begin
				result_o = src1_i - src2_i;
			end
			ALU_SLL: begin
				result_o = src1_i << shamt;
			end
			ALU_SLT: begin
				result_o = {{(`EXU_DATA_WIDTH-1){1'b0}}, lt_signed};
			end
			ALU_SLTU: begin
				result_o = {{(`EXU_DATA_WIDTH-1){1'b0}}, lt_unsigned};
			end
			ALU_XOR: begin
				result_o = src1_i ^ src2_i;
			end
			ALU_SRL: begin
				result_o = src1_i >> shamt;
			end
			ALU_SRA: begin
				result_o = $unsigned($signed(src1_i) >>> shamt);
			end
			ALU_OR: begin
				result_o = src1_i | src2_i;
			end
			ALU_AND: begin
				result_o = src1_i & src2_i;
			end
			// lui carries its immediate on src2
			ALU_PASS2: begin
				result_o = src2_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- exu_control.sv
// execute handshake controller
`default_nettype none

module exu_control (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic idu_valid_i,
	input  wire logic lsu_ready_i,
	output logic      exu_ready_o,
	output logic      exu_valid_o,
	output logic      retire_o,
	output logic      stall_o
);

	typedef enum logic [1:0] {
		ST_WAIT_IDU = 2'd0,
		ST_RUN      = 2'd1,
		ST_WAIT_LSU = 2'd2
	} state_e;

	state_e state;
	state_e state_next;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_WAIT_IDU;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_WAIT_IDU: begin
				if (idu_valid_i) begin
					state_next = ST_RUN;
				end
			end
			// first valid cycle, result goes out now or we hold it
			ST_RUN: begin
				state_next = lsu_ready_i ? ST_WAIT_IDU : ST_WAIT_LSU;
			end
			ST_WAIT_LSU: begin
				if (lsu_ready_i) begin
					state_next = ST_WAIT_IDU;
				end
			end
			default: begin
				state_next = ST_WAIT_IDU;
			end
		endcase
	end

	assign exu_ready_o = (state == ST_WAIT_IDU);
	assign exu_valid_o = (state == ST_RUN) || (state == ST_WAIT_LSU);

	// strobes for the perf counters
	assign retire_o = exu_valid_o & lsu_ready_i;
	assign stall_o  = exu_valid_o & ~lsu_ready_i;

endmodule

`default_nettype wire

//--- exu_perf_counter.sv
// execute stage performance counters
`default_nettype none
`include "exu_config.svh"

module exu_perf_counter (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  retire_i,
	input  wire logic                  stall_i,
	output logic [`EXU_PERF_WIDTH-1:0] retired_count_o,
	output logic [`EXU_PERF_WIDTH-1:0] stall_count_o
);

	// instructions handed to the memory stage
	always_ff @(posedge clock) begin
		if (reset) begin
			retired_count_o <= '0;
		end else if (retire_i) begin
			retired_count_o <= retired_count_o + `EXU_PERF_WIDTH'(1);
		end
	end

	// cycles held valid while memory is busy
	always_ff @(posedge clock) begin
		if (reset) begin
			stall_count_o <= '0;
		end else if (stall_i) begin
			stall_count_o <= stall_count_o + `EXU_PERF_WIDTH'(1);
		end
	end

endmodule

`default_nettype wire

//--- exu.sv
// execute stage datapath
`default_nettype none
`include "exu_config.svh"

module exu (
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire logic [`EXU_DATA_WIDTH-1:0]    reg1_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0]    reg2_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0]    pc_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0]    imm_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0]    csr_rdata_i,
	input  wire exu_pkg::alu_op_e              alu_op_i,
	input  wire exu_pkg::src1_sel_e            src1_sel_i,
	input  wire exu_pkg::src2_sel_e            src2_sel_i,
	input  wire exu_pkg::csr_op_e              csr_op_i,
	input  wire logic [`EXU_CSR_ADDR_WIDTH-1:0] csr_waddr_i,
	input  wire logic                          wd_i,
	input  wire logic [`EXU_REG_ADDR_WIDTH-1:0] wreg_i,
	input  wire exu_pkg::load_type_e           load_type_i,
	input  wire exu_pkg::store_type_e          store_type_i,
	input  wire logic                          ebreak_i,
	input  wire logic                          idu_valid_i,
	input  wire logic                          lsu_ready_i,
	output logic                               exu_ready_o,
	output logic                               exu_valid_o,
	output logic                               retire_o,
	output logic                               stall_o,
	output logic [`EXU_DATA_WIDTH-1:0]         alu_result_o,
	output logic [`EXU_DATA_WIDTH-1:0]         csr_wdata_o,
	output logic [`EXU_CSR_ADDR_WIDTH-1:0]     csr_waddr_o,
	output exu_pkg::csr_op_e                   csr_op_o,
	output logic                               mem_wen_o,
	output logic [`EXU_DATA_WIDTH-1:0]         mem_wdata_o,
	output exu_pkg::load_type_e                load_type_o,
	output exu_pkg::store_type_e               store_type_o,
	output logic                               wd_o,
	output logic [`EXU_REG_ADDR_WIDTH-1:0]     wreg_o,
	output logic [`EXU_DATA_WIDTH-1:0]         pc_o,
	output logic                               ebreak_o
);

	import exu_pkg::*;

	logic [`EXU_DATA_WIDTH-1:0] src1;
	logic [`EXU_DATA_WIDTH-1:0] src2;

	always_comb begin
		case (src1_sel_i)
			SRC1_REG1: src1 = reg1_i;
			SRC1_PC:   src1 = pc_i;
			SRC1_CSR:  src1 = csr_rdata_i;
			default:   src1 = '0;
		endcase
	end

	// four gives pc + 4 for jal/jalr link
	always_comb begin
		case (src2_sel_i)
			SRC2_REG2: src2 = reg2_i;
			SRC2_IMM:  src2 = imm_i;
			SRC2_FOUR: src2 = `EXU_DATA_WIDTH'(4);
			default:   src2 = '0;
		endcase
	end

	alu u_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.op_i     (alu_op_i),
		.result_o (alu_result_o)
	);

	// csrrs sets bits from reg1 on top of the old value
	always_comb begin
		case (csr_op_i)
			CSR_CSRRW: csr_wdata_o = reg1_i;
			CSR_CSRRS: csr_wdata_o = reg1_i | csr_rdata_i;
			default:   csr_wdata_o = '0;
		endcase
	end

	assign csr_waddr_o  = csr_waddr_i;
	assign csr_op_o     = csr_op_i;
	assign mem_wen_o    = (store_type_i != STORE_NONE);
	assign mem_wdata_o  = reg2_i;
	assign load_type_o  = load_type_i;
	assign store_type_o = store_type_i;
	assign wd_o         = wd_i;
	assign wreg_o       = wreg_i;
	assign pc_o         = pc_i;
	assign ebreak_o     = ebreak_i;

	exu_control u_control (
		.clock       (clock),
		.reset       (reset),
		.idu_valid_i (idu_valid_i),
		.lsu_ready_i (lsu_ready_i),
		.exu_ready_o (exu_ready_o),
		.exu_valid_o (exu_valid_o),
		.retire_o    (retire_o),
		.stall_o     (stall_o)
	);

endmodule

`default_nettype wire

//--- exu_top.sv
// execute unit with perf counters
`default_nettype none
`include "exu_config.svh"

module exu_top (
	input  wire logic                           clock,
	input  wire logic                           reset,
	input  wire logic [`EXU_DATA_WIDTH-1:0]     reg1_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0]     reg2_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0]     pc_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0]     imm_i,
	input  wire logic [`EXU_DATA_WIDTH-1:0]     csr_rdata_i,
	input  wire exu_pkg::alu_op_e               alu_op_i,
	input  wire exu_pkg::src1_sel_e             src1_sel_i,
	input  wire exu_pkg::src2_sel_e             src2_sel_i,
	input  wire exu_pkg::csr_op_e               csr_op_i,
	input  wire logic [`EXU_CSR_ADDR_WIDTH-1:0] csr_waddr_i,
	input  wire logic                           wd_i,
	input  wire logic [`EXU_REG_ADDR_WIDTH-1:0] wreg_i,
	input  wire exu_pkg::load_type_e            load_type_i,
	input  wire exu_pkg::store_type_e           store_type_i,
	input  wire logic                           ebreak_i,
	input  wire logic                           idu_valid_i,
	input  wire logic                           lsu_ready_i,
	output logic                                exu_ready_o,
	output logic                                exu_valid_o,
	output logic [`EXU_DATA_WIDTH-1:0]          alu_result_o,
	output logic [`EXU_DATA_WIDTH-1:0]          csr_wdata_o,
	output logic [`EXU_CSR_ADDR_WIDTH-1:0]      csr_waddr_o,
	output exu_pkg::csr_op_e                    csr_op_o,
	output logic                                mem_wen_o,
	output logic [`EXU_DATA_WIDTH-1:0]          mem_wdata_o,
	output exu_pkg::load_type_e                 load_type_o,
	output exu_pkg::store_type_e                store_type_o,
	output logic                                wd_o,
	output logic [`EXU_REG_ADDR_WIDTH-1:0]      wreg_o,
	output logic [`EXU_DATA_WIDTH-1:0]          pc_o,
	output logic                                ebreak_o,
	output logic [`EXU_PERF_WIDTH-1:0]          retired_count_o,
	output logic [`EXU_PERF_WIDTH-1:0]          stall_count_o
);

	logic retire;
	logic stall;

	exu u_exu (
		.clock        (clock),
		.reset        (reset),
		.reg1_i       (reg1_i),
		.reg2_i       (reg2_i),
		.pc_i         (pc_i),
		.imm_i        (imm_i),
		.csr_rdata_i  (csr_rdata_i),
		.alu_op_i     (alu_op_i),
		.src1_sel_i   (src1_sel_i),
		.src2_sel_i   (src2_sel_i),
		.csr_op_i     (csr_op_i),
		.csr_waddr_i  (csr_waddr_i),
		.wd_i         (wd_i),
		.wreg_i       (wreg_i),
		.load_type_i  (load_type_i),
		.store_type_i (store_type_i),
		.ebreak_i     (ebreak_i),
		.idu_valid_i  (idu_valid_i),
		.lsu_ready_i  (lsu_ready_i),
		.exu_ready_o  (exu_ready_o),
		.exu_valid_o  (exu_valid_o),
		.retire_o     (retire),
		.stall_o      (stall),
		.alu_result_o (alu_result_o),
		.csr_wdata_o  (csr_wdata_o),
		.csr_waddr_o  (csr_waddr_o),
		.csr_op_o     (csr_op_o),
		.mem_wen_o    (mem_wen_o),
		.mem_wdata_o  (mem_wdata_o),
		.load_type_o  (load_type_o),
		.store_type_o (store_type_o),
		.wd_o         (wd_o),
		.wreg_o       (wreg_o),
		.pc_o         (pc_o),
		.ebreak_o     (ebreak_o)
	);

	// counts retirements and memory back-pressure
	exu_perf_counter u_perf (
		.clock           (clock),
		.reset           (reset),
		.retire_i        (retire),
		.stall_i         (stall),
		.retired_count_o (retired_count_o),
		.stall_count_o   (stall_count_o)
	);

endmodule

`default_nettype wire

//--- tb_exu_top.sv
// execute stage testbench
`default_nettype none
`include "exu_config.svh"

module tb_exu_top;

	timeunit 1ns;
	timeprecision 1ps;

	import exu_pkg::*;

	localparam int DW = `EXU_DATA_WIDTH;
	localparam int PW = `EXU_PERF_WIDTH;
	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int READY_LIMIT = 10;
	localparam int MAX_STALL = 8;
	// four cycles per instruction leaves slack over the two it needs
	localparam int RUN_CYCLES = RESET_CYCLES + 12 * 4 + 8 * 4 + 3 * 4 + 6 * 4
		+ 3 * (4 + MAX_STALL);
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;

	logic clock;
	logic reset;
	logic [DW-1:0] reg1, reg2, pc, imm, csr_rdata;
	alu_op_e alu_op;
	src1_sel_e src1_sel;
	src2_sel_e src2_sel;
	csr_op_e csr_op;
	logic [`EXU_CSR_ADDR_WIDTH-1:0] csr_waddr;
	logic wd;
	logic [`EXU_REG_ADDR_WIDTH-1:0] wreg;
	load_type_e load_type;
	store_type_e store_type;
	logic ebreak, idu_valid, lsu_ready;

	logic exu_ready, exu_valid, mem_wen, wd_out, ebreak_out;
	logic [DW-1:0] alu_result, csr_wdata, mem_wdata, pc_out;
	logic [`EXU_CSR_ADDR_WIDTH-1:0] csr_waddr_out;
	csr_op_e csr_op_out;
	load_type_e load_type_out;
	store_type_e store_type_out;
	logic [`EXU_REG_ADDR_WIDTH-1:0] wreg_out;
	logic [PW-1:0] retired_count, stall_count;

	integer seed = 32'h51ad;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	logic [PW-1:0] exp_retired = '0;
	logic [PW-1:0] exp_stall = '0;

	exu_top u_dut (
		.clock (clock), .reset (reset),
		.reg1_i (reg1), .reg2_i (reg2), .pc_i (pc), .imm_i (imm), .csr_rdata_i (csr_rdata),
		.alu_op_i (alu_op), .src1_sel_i (src1_sel), .src2_sel_i (src2_sel),
		.csr_op_i (csr_op), .csr_waddr_i (csr_waddr), .wd_i (wd), .wreg_i (wreg),
		.load_type_i (load_type), .store_type_i (store_type), .ebreak_i (ebreak),
		.idu_valid_i (idu_valid), .lsu_ready_i (lsu_ready),
		.exu_ready_o (exu_ready), .exu_valid_o (exu_valid),
		.alu_result_o (alu_result), .csr_wdata_o (csr_wdata), .csr_waddr_o (csr_waddr_out),
		.csr_op_o (csr_op_out), .mem_wen_o (mem_wen), .mem_wdata_o (mem_wdata),
		.load_type_o (load_type_out), .store_type_o (store_type_out),
		.wd_o (wd_out), .wreg_o (wreg_out), .pc_o (pc_out), .ebreak_o (ebreak_out),
		.retired_count_o (retired_count), .stall_count_o (stall_count)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// expected alu result from the rv32i definitions
	function automatic logic [DW-1:0] ref_alu(input alu_op_e op, input logic [DW-1:0] a,
		input logic [DW-1:0] b);
		logic [2*DW-1:0] wide;
		wide = {{DW{a[DW-1]}}, a} >> b[4:0];
		case (op)
			ALU_ADD:   return a + b;
			ALU_SUB:   return a + ~b + 1;
			ALU_SLL:   return a << b[4:0];
			ALU_SLT:   return (a[DW-1] != b[DW-1]) ? DW'(a[DW-1]) : DW'(a < b);
			ALU_SLTU:  return DW'(a < b);
			ALU_XOR:   return a ^ b;
			ALU_SRL:   return a >> b[4:0];
			ALU_SRA:   return wide[DW-1:0];
			ALU_OR:    return a | b;
			ALU_AND:   return a & b;
			ALU_PASS2: return b;
			default:   return '0;
		endcase
	endfunction

	function automatic logic [DW-1:0] ref_csr(input csr_op_e op, input logic [DW-1:0] rs1,
		input logic [DW-1:0] old);
		if (op == CSR_CSRRW) return rs1;
		if (op == CSR_CSRRS) return rs1 | old;
		return '0;
	endfunction

	function automatic logic [DW-1:0] pick_src1(input src1_sel_e sel);
		if (sel == SRC1_REG1) return reg1;
		if (sel == SRC1_PC) return pc;
		if (sel == SRC1_CSR) return csr_rdata;
		return '0;
	endfunction

	function automatic logic [DW-1:0] pick_src2(input src2_sel_e sel);
		if (sel == SRC2_REG2) return reg2;
		if (sel == SRC2_IMM) return imm;
		if (sel == SRC2_FOUR) return 4;
		return '0;
	endfunction

	task automatic compare_data(input string tag, input string what, input logic [DW-1:0] exp,
		input logic [DW-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected %h, actual %h", tag, what, exp, act);
		end
	endtask

	task automatic compare_count(input string tag, input string what, input logic [PW-1:0] exp,
		input logic [PW-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected %0d, actual %0d", tag, what, exp, act);
		end
	endtask

	task automatic compare_bit(input string tag, input string what, input logic exp,
		input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected %b, actual %b", tag, what, exp, act);
		end
	endtask

	task automatic compare_store(input string tag, input store_type_e exp, input store_type_e act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s store type: expected %s, actual %s", tag, exp.name(), act.name());
		end
	endtask

	task automatic compare_load(input string tag, input load_type_e exp, input load_type_e act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s load type: expected %s, actual %s", tag, exp.name(), act.name());
		end
	endtask

	task automatic compare_csr_op(input string tag, input csr_op_e exp, input csr_op_e act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s csr op: expected %s, actual %s", tag, exp.name(), act.name());
		end
	endtask

	// one instruction through both handshakes with n_stall cycles of memory back-pressure
	task automatic send_instr(input string tag, input int n_stall);
		int waited;
		int i;
		logic [DW-1:0] exp_result;
		logic [DW-1:0] exp_csr;
		exp_result = ref_alu(alu_op, pick_src1(src1_sel), pick_src2(src2_sel));
		exp_csr = ref_csr(csr_op, reg1, csr_rdata);
		waited = 0;
		idu_valid = 1'b1;
		lsu_ready = 1'b0;
		while (!exu_ready && waited < READY_LIMIT) begin
			@(posedge clock);
			#2;
			waited++;
		end
		if (!exu_ready) begin
			errors++;
			$display("%s: the stage never became ready to take an instruction", tag);
			idu_valid = 1'b0;
			return;
		end
		compare_bit(tag, "valid before accept", 1'b0, exu_valid);
		@(posedge clock);
		#2;
		idu_valid = 1'b0;
		for (i = 0; i <= n_stall; i++) begin
			lsu_ready = (i == n_stall);
			compare_bit(tag, "valid", 1'b1, exu_valid);
			compare_bit(tag, "ready while busy", 1'b0, exu_ready);
			compare_data(tag, "alu result", exp_result, alu_result);
			compare_data(tag, "csr wdata", exp_csr, csr_wdata);
			compare_data(tag, "mem wdata", reg2, mem_wdata);
			@(posedge clock);
			#2;
		end
		lsu_ready = 1'b0;
		exp_retired = exp_retired + 1;
		exp_stall = exp_stall + PW'(n_stall);
		compare_bit(tag, "valid after transfer", 1'b0, exu_valid);
		compare_bit(tag, "ready after transfer", 1'b1, exu_ready);
		compare_count(tag, "retired count", exp_retired, retired_count);
		compare_count(tag, "stall count", exp_stall, stall_count);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		$display("%s: %s, %0d errors", name, (errors == errors_before) ? "ok" : "FAILED",
			errors - errors_before);
	endtask

	task automatic check_reset_state();
		int start;
		start = errors;
		compare_bit("reset", "ready", 1'b1, exu_ready);
		compare_bit("reset", "valid", 1'b0, exu_valid);
		compare_count("reset", "retired count", '0, retired_count);
		compare_count("reset", "stall count", '0, stall_count);
		report_test("reset", start);
	endtask

	task automatic sweep_alu_ops();
		int start;
		int k;
		start = errors;
		src1_sel = SRC1_REG1;
		src2_sel = SRC2_REG2;
		// code 15 is unused and must give zero
		for (k = 0; k < 12; k++) begin
			alu_op = (k == 11) ? alu_op_e'(4'd15) : alu_op_e'(k);
			reg1 = $random(seed);
			reg2 = $random(seed);
			send_instr("alu_ops", 0);
		end
		report_test("alu_ops", start);
	endtask

	task automatic walk_operand_selects();
		int start;
		int k;
		start = errors;
		alu_op = ALU_ADD;
		for (k = 0; k < 8; k++) begin
			reg1 = $random(seed);
			reg2 = $random(seed);
			pc = $random(seed);
			imm = $random(seed);
			csr_rdata = $random(seed);
			src1_sel = (k < 4) ? src1_sel_e'(k) : SRC1_PC;
			src2_sel = (k < 4) ? SRC2_REG2 : src2_sel_e'(k - 4);
			send_instr("operand_select", 0);
		end
		report_test("operand_select", start);
	endtask

	task automatic exercise_csr_data();
		int start;
		int k;
		start = errors;
		for (k = 0; k < 3; k++) begin
			csr_op = csr_op_e'(k);
			csr_waddr = $random(seed);
			reg1 = $random(seed);
			csr_rdata = $random(seed);
			send_instr("csr_data", 0);
			compare_data("csr_data", "csr waddr", DW'(csr_waddr), DW'(csr_waddr_out));
			compare_csr_op("csr_data", csr_op, csr_op_out);
		end
		csr_op = CSR_NONE;
		report_test("csr_data", start);
	endtask

	task automatic pass_through_fields();
		int start;
		int k;
		start = errors;
		for (k = 0; k < 6; k++) begin
			load_type = load_type_e'(k);
			store_type = store_type_e'(k % 4);
			wd = k[0];
			wreg = $random(seed);
			pc = $random(seed);
			reg2 = $random(seed);
			ebreak = (k == 5);
			send_instr("mem_fields", 0);
			// codes 1 to 3 are sb, sh and sw
			compare_bit("mem_fields", "mem wen", (k % 4) != 0, mem_wen);
			compare_store("mem_fields", store_type, store_type_out);
			compare_load("mem_fields", load_type, load_type_out);
			compare_bit("mem_fields", "wd", wd, wd_out);
			compare_data("mem_fields", "wreg", DW'(wreg), DW'(wreg_out));
			compare_data("mem_fields", "pc", pc, pc_out);
			compare_bit("mem_fields", "ebreak", ebreak, ebreak_out);
		end
		report_test("mem_fields", start);
	endtask

	task automatic hold_under_back_pressure();
		int start;
		int k;
		int n;
		start = errors;
		alu_op = ALU_XOR;
		src1_sel = SRC1_REG1;
		src2_sel = SRC2_IMM;
		store_type = STORE_SW;
		for (k = 0; k < 3; k++) begin
			reg1 = $random(seed);
			reg2 = $random(seed);
			imm = $random(seed);
			n = 1 + ($random(seed) & (MAX_STALL - 1));
			send_instr("back_pressure", n);
		end
		compare_count("back_pressure", "transfers since reset", PW'(12 + 8 + 3 + 6 + 3),
			retired_count);
		report_test("back_pressure", start);
	endtask

	initial begin
		reset = 1'b1;
		idu_valid = 1'b0;
		lsu_ready = 1'b0;
		{reg1, reg2, pc, imm, csr_rdata} = '0;
		alu_op = ALU_ADD;
		src1_sel = SRC1_ZERO;
		src2_sel = SRC2_ZERO;
		csr_op = CSR_NONE;
		csr_waddr = '0;
		wd = 1'b0;
		wreg = '0;
		load_type = LOAD_NONE;
		store_type = STORE_NONE;
		ebreak = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		reset = 1'b0;
		check_reset_state();
		sweep_alu_ops();
		walk_operand_selects();
		exercise_csr_data();
		pass_through_fields();
		hold_under_back_pressure();
		$display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// stops a hung handshake
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
exu_pkg.sv
alu.sv
exu_control.sv
exu_perf_counter.sv
exu.sv
exu_top.sv
tb_exu_top.sv

//--- Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - alu.sv
      - exu_control.sv
      - exu_perf_counter.sv
      - exu.sv
      - exu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exu_top.sv
